// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= pic_ctrl_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= All tests passed!

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run and look for the pass message"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS SIM_ARGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== sim.f ====
+incdir+src
src/pic_reg_pkg.sv
src/pic_int_pkg.sv
src/pic_reg_decode.sv
src/pic_reg_file.sv
src/pic_gateway.sv
src/pic_prio_tree.sv
src/pic_claim.sv
src/pic_ctrl.sv
verification/pic_ctrl_assert.sv
verification/pic_ctrl_tb.sv

// ==== src/pic_cfg.svh ====
`ifndef PIC_CFG_SVH
`define PIC_CFG_SVH

// Source slots, slot 0 is reserved and never pending
`define PIC_TOTAL_INT     16
`define PIC_IDX_BITS      4
`define PIC_PRIO_BITS     4
`define PIC_ID_BITS       8

////////////////////////////////////////////////////////////////////////////
// Register map
////////////////////////////////////////////////////////////////////////////
`define PIC_BASE_ADDR     32'hf00c_0000
// Priority region sits at offset 0
`define PIC_PEND_OFS      32'h0000_1000
`define PIC_ENABLE_OFS    32'h0000_2000
`define PIC_CONFIG_OFS    32'h0000_3000   // Single word, holds the order bit
`define PIC_GW_CONFIG_OFS 32'h0000_4000
`define PIC_GW_CLEAR_OFS  32'h0000_5000   // Write only

`endif

// ==== src/pic_claim.sv ====
`timescale 1ns/1ps
`default_nettype none

module pic_claim (
   input  logic                   clk,
   input  logic                   reset,
   input  pic_int_pkg::pic_cand_t winner,
   input  logic                   order,
   input  pic_int_pkg::prio_t     meicurpl,
   input  pic_int_pkg::prio_t     meipt,
   output pic_int_pkg::id_t       claimid,
   output pic_int_pkg::prio_t     pl,
   output logic                   mexintpend,
   output logic                   mhwakeup
);
   import pic_int_pkg::*;

   prio_t pl_next;      // Winner level back in the software encoding
   prio_t meipt_eff;
   prio_t curpl_eff;
   prio_t max_level;

   assign pl_next   = order ? ~winner.prio : winner.prio;
   assign meipt_eff = order ? ~meipt : meipt;
   assign curpl_eff = order ? ~meicurpl : meicurpl;
   assign max_level = order ? '0 : '1;

   always_ff @(posedge clk) begin
      if (reset) begin
         claimid    <= '0;
         pl         <= '0;
         mexintpend <= 1'b0;
         mhwakeup   <= 1'b0;
      end else begin
         claimid    <= winner.id;
         pl         <= pl_next;
         // Compare in the effective domain, larger is always more urgent
         mexintpend <= (winner.prio > meipt_eff) && (winner.prio > curpl_eff);
         mhwakeup   <= (pl_next == max_level);
      end
   end

endmodule

`default_nettype wire

// ==== src/pic_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pic_cfg.svh"

module pic_ctrl (
   input  logic                       clk,
   input  logic                       reset,
   input  logic [`PIC_TOTAL_INT-1:0]  extintsrc_req,
   input  logic [31:0]                picm_addr,
   input  logic [31:0]                picm_wr_data,
   input  logic                       picm_wren,
   input  logic                       picm_rden,
   input  logic [`PIC_PRIO_BITS-1:0]  meicurpl,      // Current level of the core
   input  logic [`PIC_PRIO_BITS-1:0]  meipt,         // Threshold of the core
   output logic                       mexintpend,
   output logic                       mhwakeup,
   output logic [`PIC_ID_BITS-1:0]    claimid,
   output logic [`PIC_PRIO_BITS-1:0]  pl,
   output logic [31:0]                picm_rd_data
);
   import pic_reg_pkg::*;
   import pic_int_pkg::*;

   pic_sel_t                       sel;
   logic [`PIC_TOTAL_INT-1:0]      enable;
   logic [`PIC_TOTAL_INT-1:0]      gw_clear;
   logic [`PIC_TOTAL_INT-1:0]      pending;
   prio_t [`PIC_TOTAL_INT-1:0]     prio;
   gw_cfg_t [`PIC_TOTAL_INT-1:0]   gw_cfg;
   logic                           order;
   pic_cand_t                      winner;

   ////////////////////////////////////////////////////////////////////////////
   // Register side
   ////////////////////////////////////////////////////////////////////////////
   pic_reg_decode u_decode (
      .clk          (clk),
      .reset        (reset),
      .picm_addr    (picm_addr),
      .picm_wr_data (picm_wr_data),
      .picm_wren    (picm_wren),
      .picm_rden    (picm_rden),
      .sel          (sel)
   );

   pic_reg_file u_reg_file (
      .clk      (clk),
      .reset    (reset),
      .sel      (sel),
      .pending  (pending),
      .enable   (enable),
      .prio     (prio),
      .gw_cfg   (gw_cfg),
      .gw_clear (gw_clear),
      .order    (order),
      .rd_data  (picm_rd_data)
   );

   ////////////////////////////////////////////////////////////////////////////
   // Interrupt side
   ////////////////////////////////////////////////////////////////////////////
   pic_gateway u_gateway (
      .clk           (clk),
      .reset         (reset),
      .extintsrc_req (extintsrc_req),
      .gw_cfg        (gw_cfg),
      .gw_clear      (gw_clear),
      .pending       (pending)
   );

   pic_prio_tree u_tree (
      .pending (pending),
      .enable  (enable),
      .prio    (prio),
      .order   (order),
      .winner  (winner)
   );

   pic_claim u_claim (
      .clk        (clk),
      .reset      (reset),
      .winner     (winner),
      .order      (order),
      .meicurpl   (meicurpl),
      .meipt      (meipt),
      .claimid    (claimid),
      .pl         (pl),
      .mexintpend (mexintpend),
      .mhwakeup   (mhwakeup)
   );

endmodule

`default_nettype wire

// ==== src/pic_gateway.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pic_cfg.svh"

module pic_gateway (
   input  logic                                      clk,
   input  logic                                      reset,
   input  logic [`PIC_TOTAL_INT-1:0]                 extintsrc_req,
   input  pic_int_pkg::gw_cfg_t [`PIC_TOTAL_INT-1:0] gw_cfg,
   input  logic [`PIC_TOTAL_INT-1:0]                 gw_clear,
   output logic [`PIC_TOTAL_INT-1:0]                 pending
);

   // Source 0 is reserved, so only slots 1 and up get hardware
   logic [`PIC_TOTAL_INT-1:1] sync_q1;
   logic [`PIC_TOTAL_INT-1:1] sync_q2;
   logic [`PIC_TOTAL_INT-1:1] edge_q;      // Edge latch per source
   logic [`PIC_TOTAL_INT-1:1] edge_next;
   logic [`PIC_TOTAL_INT-1:1] req_pol;     // Synchronized request after polarity

   always_ff @(posedge clk) begin
      if (reset) begin
         sync_q1 <= '0;
         sync_q2 <= '0;
         edge_q  <= '0;
      end else begin
         sync_q1 <= extintsrc_req[`PIC_TOTAL_INT-1:1];
         sync_q2 <= sync_q1;
         edge_q  <= edge_next;
      end
   end

   always_comb begin
      pending = '0;
      for (int i = 1; i < `PIC_TOTAL_INT; i++) begin
         req_pol[i]   = sync_q2[i] ^ gw_cfg[i].polarity;
         // Latch only runs in edge mode and holds until software clears it
         edge_next[i] = gw_cfg[i].edge_type & (req_pol[i] | (edge_q[i] & ~gw_clear[i]));
         pending[i]   = gw_cfg[i].edge_type ? (req_pol[i] | edge_q[i]) : req_pol[i];
      end
   end

endmodule

`default_nettype wire

// ==== src/pic_int_pkg.sv ====
`default_nettype none

`include "pic_cfg.svh"

package pic_int_pkg;

   typedef logic [`PIC_PRIO_BITS-1:0] prio_t;
   typedef logic [`PIC_ID_BITS-1:0]   id_t;

   // One entry of the comparator tree
   typedef struct packed {
      prio_t prio;   // Effective priority, already order adjusted
      id_t   id;
   } pic_cand_t;

   // Bit 1 selects edge type, bit 0 inverts the request
   typedef struct packed {
      logic edge_type;
      logic polarity;
   } gw_cfg_t;

endpackage

`default_nettype wire

// ==== src/pic_prio_tree.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pic_cfg.svh"

module pic_prio_tree (
   input  logic [`PIC_TOTAL_INT-1:0]               pending,
   input  logic [`PIC_TOTAL_INT-1:0]               enable,
   input  pic_int_pkg::prio_t [`PIC_TOTAL_INT-1:0] prio,
   input  logic                                    order,
   output pic_int_pkg::pic_cand_t                  winner
);
   import pic_int_pkg::*;

   localparam int levels = $clog2(`PIC_TOTAL_INT);

   pic_cand_t [levels:0][`PIC_TOTAL_INT-1:0] lvl;

   // Left entry carries the lower id, so it keeps a tie
   function automatic pic_cand_t pick(input pic_cand_t a, input pic_cand_t b);
      return (b.prio > a.prio) ? b : a;
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // Pairwise reduction, half the entries per level
   ////////////////////////////////////////////////////////////////////////////
   always_comb begin
      lvl = '0;
      for (int i = 0; i < `PIC_TOTAL_INT; i++) begin
         // Masked sources drop to 0 and can only win an empty round
         lvl[0][i].prio = (pending[i] & enable[i]) ? (order ? ~prio[i] : prio[i]) : '0;
         lvl[0][i].id   = id_t'(i);
      end
      for (int l = 0; l < levels; l++) begin
         for (int m = 0; m < (`PIC_TOTAL_INT >> (l + 1)); m++) begin
            lvl[l+1][m] = pick(lvl[l][2*m], lvl[l][2*m+1]);
         end
      end
   end

   assign winner = lvl[levels][0];

endmodule

`default_nettype wire

// ==== src/pic_reg_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pic_cfg.svh"

module pic_reg_decode (
   input  logic                  clk,
   input  logic                  reset,
   input  logic [31:0]           picm_addr,
   input  logic [31:0]           picm_wr_data,
   input  logic                  picm_wren,
   input  logic                  picm_rden,
   output pic_reg_pkg::pic_sel_t sel
);
   import pic_reg_pkg::*;

   // Each per-source region is one word per source above this bit
   localparam int unsigned blk_lsb = `PIC_IDX_BITS + 2;

   localparam logic [31:0] prio_base  = `PIC_BASE_ADDR;
   localparam logic [31:0] pend_base  = `PIC_BASE_ADDR + `PIC_PEND_OFS;
   localparam logic [31:0] en_base    = `PIC_BASE_ADDR + `PIC_ENABLE_OFS;
   localparam logic [31:0] cfg_addr   = `PIC_BASE_ADDR + `PIC_CONFIG_OFS;
   localparam logic [31:0] gwcfg_base = `PIC_BASE_ADDR + `PIC_GW_CONFIG_OFS;
   localparam logic [31:0] gwclr_base = `PIC_BASE_ADDR + `PIC_GW_CLEAR_OFS;

   pic_req_t req_q;

   always_ff @(posedge clk) begin
      if (reset) begin
         req_q <= '0;
      end else begin
         req_q.wren    <= picm_wren;
         req_q.rden    <= picm_rden;
         req_q.addr    <= picm_addr;
         req_q.wr_data <= picm_wr_data;
      end
   end

   always_comb begin
      case (req_q.addr[31:blk_lsb])
         prio_base[31:blk_lsb]:  sel.region = region_priority;
         pend_base[31:blk_lsb]:  sel.region = region_pending;   // Index ignored
         en_base[31:blk_lsb]:    sel.region = region_enable;
         gwcfg_base[31:blk_lsb]: sel.region = region_gw_config;
         gwclr_base[31:blk_lsb]: sel.region = region_gw_clear;
         // Config is a single word, neighbours decode to nothing
         cfg_addr[31:blk_lsb]:
            sel.region = (req_q.addr == cfg_addr) ? region_config : region_none;
         default:                sel.region = region_none;
      endcase
      sel.idx     = req_q.addr[blk_lsb-1:2];
      sel.wren    = req_q.wren;
      sel.rden    = req_q.rden;
      sel.wr_data = req_q.wr_data;
   end

endmodule

`default_nettype wire

// ==== src/pic_reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pic_cfg.svh"

module pic_reg_file (
   input  logic                                      clk,
   input  logic                                      reset,
   input  pic_reg_pkg::pic_sel_t                     sel,
   input  logic [`PIC_TOTAL_INT-1:0]                 pending,
   output logic [`PIC_TOTAL_INT-1:0]                 enable,
   output pic_int_pkg::prio_t [`PIC_TOTAL_INT-1:0]   prio,
   output pic_int_pkg::gw_cfg_t [`PIC_TOTAL_INT-1:0] gw_cfg,
   output logic [`PIC_TOTAL_INT-1:0]                 gw_clear,
   output logic                                      order,
   output logic [31:0]                               rd_data
);
   import pic_reg_pkg::*;

   logic idx_ok;

   assign idx_ok = (sel.idx != '0);   // Slot 0 has no registers behind it

   ////////////////////////////////////////////////////////////////////////////
   // Per-source configuration
   ////////////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (reset) begin
         prio   <= '0;
         enable <= '0;
         gw_cfg <= '0;
      end else if (sel.wren && idx_ok) begin
         case (sel.region)
            region_priority:  prio[sel.idx]   <= sel.wr_data[`PIC_PRIO_BITS-1:0];
            region_enable:    enable[sel.idx] <= sel.wr_data[0];
            region_gw_config: gw_cfg[sel.idx] <= sel.wr_data[1:0];
            default: ;
         endcase
      end
   end

   // Global priority order, 1 makes 0 the most urgent level
   always_ff @(posedge clk) begin
      if (reset) begin
         order <= 1'b0;
      end else if (sel.wren && sel.region == region_config) begin
         order <= sel.wr_data[0];
      end
   end

   // One-cycle clear of the edge latch
   always_comb begin
      gw_clear = '0;
      if (sel.wren && idx_ok && sel.region == region_gw_clear) begin
         gw_clear[sel.idx] = 1'b1;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Read data, zero-extended and zero when no read is in flight
   ////////////////////////////////////////////////////////////////////////////
   always_comb begin
      rd_data = '0;
      if (sel.rden) begin
         case (sel.region)
            region_priority:  rd_data[`PIC_PRIO_BITS-1:0] = prio[sel.idx];
            region_enable:    rd_data[0]                  = enable[sel.idx];
            region_gw_config: rd_data[1:0]                = gw_cfg[sel.idx];
            region_config:    rd_data[0]                  = order;
            region_pending:   rd_data[`PIC_TOTAL_INT-1:0] = pending;
            default: ;
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== src/pic_reg_pkg.sv ====
`default_nettype none

`include "pic_cfg.svh"

package pic_reg_pkg;

   // Register request as captured from the strobe port
   typedef struct packed {
      logic        wren;
      logic        rden;
      logic [31:0] addr;
      logic [31:0] wr_data;
   } pic_req_t;

   typedef enum logic [2:0] {
      region_none,
      region_priority,
      region_pending,
      region_enable,
      region_config,
      region_gw_config,
      region_gw_clear
   } pic_region_e;

   // Decoded access, one cycle behind the strobe
   typedef struct packed {
      pic_region_e              region;
      logic [`PIC_IDX_BITS-1:0] idx;     // Source index within the region
      logic                     wren;
      logic                     rden;
      logic [31:0]              wr_data;
   } pic_sel_t;

endpackage

`default_nettype wire

// ==== verification/pic_ctrl_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pic_cfg.svh"

module pic_ctrl_assert (
   input logic                       clk,
   input logic                       reset,
   input logic                       picm_rden,
   input logic [`PIC_PRIO_BITS-1:0]  meicurpl,
   input logic [`PIC_PRIO_BITS-1:0]  meipt,
   input logic                       order,         // Internal order bit of the DUT
   input logic                       mexintpend,
   input logic                       mhwakeup,
   input logic [`PIC_ID_BITS-1:0]    claimid,
   input logic [`PIC_PRIO_BITS-1:0]  pl,
   input logic [31:0]                picm_rd_data
);

   int fail_count = 0;

   // Registered outputs are clear on the edge after reset is seen
   reset_clears: assert property (@(posedge clk)
      reset |=> (claimid == '0) && (pl == '0) && !mexintpend && !mhwakeup
                && (picm_rd_data == '0))
      else begin
         $error("outputs not cleared by reset");
         fail_count++;
      end

   rd_data_idle: assert property (@(posedge clk) disable iff (reset)
      !$past(picm_rden) |-> (picm_rd_data == '0))
      else begin
         $error("read data not zero without a read");
         fail_count++;
      end

   // Request only when the level beats threshold and current level
   intpend_level: assert property (@(posedge clk) disable iff (reset)
      mexintpend |-> ($past(order) ? (pl < $past(meipt)) && (pl < $past(meicurpl))
                                   : (pl > $past(meipt)) && (pl > $past(meicurpl))))
      else begin
         $error("external request with a level that does not win");
         fail_count++;
      end

   wakeup_level: assert property (@(posedge clk) disable iff (reset)
      mhwakeup |-> (pl == ($past(order) ? 4'h0 : 4'hf)))
      else begin
         $error("wake-up without the most urgent level");
         fail_count++;
      end

endmodule

bind pic_ctrl pic_ctrl_assert u_assert (
   .clk          (clk),
   .reset        (reset),
   .picm_rden    (picm_rden),
   .meicurpl     (meicurpl),
   .meipt        (meipt),
   .order        (order),
   .mexintpend   (mexintpend),
   .mhwakeup     (mhwakeup),
   .claimid      (claimid),
   .pl           (pl),
   .picm_rd_data (picm_rd_data)
);

`default_nettype wire

// ==== verification/pic_ctrl_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pic_cfg.svh"

module pic_ctrl_tb;

   // About 900 cycles of tests, so this leaves a wide margin
   localparam int timeout_cycles = 3000;

   logic                       clk;
   logic                       reset;
   logic [`PIC_TOTAL_INT-1:0]  extintsrc_req;
   logic [31:0]                picm_addr;
   logic [31:0]                picm_wr_data;
   logic                       picm_wren;
   logic                       picm_rden;
   logic [`PIC_PRIO_BITS-1:0]  meicurpl;
   logic [`PIC_PRIO_BITS-1:0]  meipt;
   logic                       mexintpend;
   logic                       mhwakeup;
   logic [`PIC_ID_BITS-1:0]    claimid;
   logic [`PIC_PRIO_BITS-1:0]  pl;
   logic [31:0]                picm_rd_data;

   // Reference copy of the programmed registers
   logic [3:0]  prio_m [`PIC_TOTAL_INT];
   logic        en_m [`PIC_TOTAL_INT];
   logic [1:0]  gw_m [`PIC_TOTAL_INT];   // {edge type, polarity}
   logic        order_m;

   integer      seed = 32'hc8177814;
   int          errors = 0;
   int          checks = 0;
   int          cycles = 0;

   pic_ctrl UUT (
      .clk           (clk),
      .reset         (reset),
      .extintsrc_req (extintsrc_req),
      .picm_addr     (picm_addr),
      .picm_wr_data  (picm_wr_data),
      .picm_wren     (picm_wren),
      .picm_rden     (picm_rden),
      .meicurpl      (meicurpl),
      .meipt         (meipt),
      .mexintpend    (mexintpend),
      .mhwakeup      (mhwakeup),
      .claimid       (claimid),
      .pl            (pl),
      .picm_rd_data  (picm_rd_data)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= timeout_cycles) begin
         $display("Timeout after %0d cycles, the tests did not finish", cycles);
         print_summary();
         $display("Test failures found");
         $finish;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////////////////////////////////////////
   function automatic logic [31:0] reg_addr(input logic [31:0] ofs, input logic [3:0] idx);
      return `PIC_BASE_ADDR + ofs + {26'd0, idx, 2'b00};
   endfunction

   // Level sources pend on the request after polarity, slot 0 never
   function automatic logic [15:0] level_pending(input logic [15:0] src);
      logic [15:0] p;
      p = '0;
      for (int i = 1; i < `PIC_TOTAL_INT; i++) begin
         p[i] = src[i] ^ gw_m[i][0];
      end
      return p;
   endfunction

   function automatic logic [15:0] idle_sources();
      logic [15:0] s;
      s = '0;
      for (int i = 1; i < `PIC_TOTAL_INT; i++) begin
         s[i] = gw_m[i][0];   // Inverted sources rest high
      end
      return s;
   endfunction

   task automatic print_summary();
      $display("Checks: %0d, value errors: %0d, assertion failures: %0d",
               checks, errors, UUT.u_assert.fail_count);
   endtask

   task automatic check_val(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
      checks++;
      assert (got === exp) else begin
         $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
         errors++;
      end
   endtask

   task automatic reg_write(input logic [31:0] addr, input logic [31:0] data);
      @(posedge clk);
      picm_wren    <= 1'b1;
      picm_addr    <= addr;
      picm_wr_data <= data;
      @(posedge clk);
      picm_wren    <= 1'b0;
   endtask

   task automatic reg_read(input logic [31:0] addr, output logic [31:0] data);
      @(posedge clk);
      picm_rden <= 1'b1;
      picm_addr <= addr;
      @(posedge clk);
      picm_rden <= 1'b0;
      @(negedge clk);
      data = picm_rd_data;   // Valid in the cycle after capture
   endtask

   task automatic config_source(input logic [3:0] idx, input logic [31:0] p_data,
                                input logic [31:0] e_data, input logic [31:0] g_data);
      reg_write(reg_addr(32'd0, idx), p_data);
      reg_write(reg_addr(`PIC_ENABLE_OFS, idx), e_data);
      reg_write(reg_addr(`PIC_GW_CONFIG_OFS, idx), g_data);
      if (idx != 4'd0) begin
         prio_m[idx] = p_data[3:0];
         en_m[idx]   = e_data[0];
         gw_m[idx]   = g_data[1:0];
      end
   endtask

   task automatic set_order(input logic o);
      logic [31:0] rd;
      reg_write(reg_addr(`PIC_CONFIG_OFS, 4'd0), {31'd0, o});
      order_m = o;
      reg_read(reg_addr(`PIC_CONFIG_OFS, 4'd0), rd);
      check_val("picm_rd_data (config)", rd, {31'd0, o});
   endtask

   task automatic check_readback(input logic [3:0] idx);
      logic [31:0] rd;
      reg_read(reg_addr(32'd0, idx), rd);
      check_val("picm_rd_data (priority)", rd, 32'(prio_m[idx]));
      reg_read(reg_addr(`PIC_ENABLE_OFS, idx), rd);
      check_val("picm_rd_data (enable)", rd, 32'(en_m[idx]));
      reg_read(reg_addr(`PIC_GW_CONFIG_OFS, idx), rd);
      check_val("picm_rd_data (gw_config)", rd, 32'(gw_m[idx]));
   endtask

   task automatic check_idle();
      check_val("claimid", 32'(claimid), 32'd0);
      check_val("pl", 32'(pl), 32'd0);
      check_val("mexintpend", 32'(mexintpend), 32'd0);
      check_val("mhwakeup", 32'(mhwakeup), 32'd0);
      check_val("picm_rd_data", picm_rd_data, 32'd0);
   endtask

   task automatic apply_sources(input logic [15:0] src, input logic [3:0] thr,
                                input logic [3:0] cur);
      @(posedge clk);
      extintsrc_req <= src;
      meipt         <= thr;
      meicurpl      <= cur;
      repeat (3) @(posedge clk);   // Two sync flops, then the claim register
      @(negedge clk);
   endtask

   // Expected claim from the enabled pending set
   task automatic check_outputs(input logic [15:0] pend);
      logic [3:0] eff;
      logic [3:0] best_eff;
      logic [7:0] best_id;
      logic [3:0] thr_eff;
      logic [3:0] cur_eff;
      logic [3:0] exp_pl;
      best_eff = '0;
      best_id  = '0;
      for (int i = 1; i < `PIC_TOTAL_INT; i++) begin
         eff = order_m ? ~prio_m[i] : prio_m[i];
         if (pend[i] && en_m[i] && eff > best_eff) begin   // Lower id keeps a tie
            best_eff = eff;
            best_id  = 8'(i);
         end
      end
      exp_pl  = order_m ? ~best_eff : best_eff;
      thr_eff = order_m ? ~meipt : meipt;
      cur_eff = order_m ? ~meicurpl : meicurpl;
      check_val("claimid", 32'(claimid), 32'(best_id));
      check_val("pl", 32'(pl), 32'(exp_pl));
      check_val("mexintpend", 32'(mexintpend),
                32'(best_eff > thr_eff && best_eff > cur_eff));
      check_val("mhwakeup", 32'(mhwakeup), 32'(exp_pl == (order_m ? 4'h0 : 4'hf)));
   endtask

   task automatic random_rounds(input int n);
      logic [31:0] r;
      logic [31:0] t;
      logic [31:0] rd;
      logic [15:0] src;
      for (int k = 0; k < n; k++) begin
         r   = $random(seed);
         t   = $random(seed);
         src = (k % 8 == 0) ? idle_sources() : r[15:0];   // Now and then nothing pends
         apply_sources(src, t[3:0], t[7:4]);
         check_outputs(level_pending(src));
         reg_read(reg_addr(`PIC_PEND_OFS, 4'd0), rd);
         check_val("picm_rd_data (pending)", rd, {16'd0, level_pending(src)});
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////////////////////////////////////////
   initial begin
      logic [31:0] r;
      logic [31:0] rd;
      logic [15:0] idle;
      reset         = 1'b1;
      extintsrc_req = '0;
      picm_addr     = '0;
      picm_wr_data  = '0;
      picm_wren     = 1'b0;
      picm_rden     = 1'b0;
      meicurpl      = '0;
      meipt         = '0;
      order_m       = 1'b0;
      for (int i = 0; i < `PIC_TOTAL_INT; i++) begin
         prio_m[i] = '0;
         en_m[i]   = 1'b0;
         gw_m[i]   = '0;
      end

      repeat (4) @(posedge clk);
      @(negedge clk);
      check_idle();
      repeat (4) @(posedge clk);
      reset <= 1'b0;
      @(negedge clk);
      check_idle();

      // Random level setup, upper data bits are dropped by the DUT
      config_source(4'd0, 32'hffff_ffff, 32'hffff_ffff, 32'hffff_ffff);
      for (int i = 1; i < `PIC_TOTAL_INT; i++) begin
         r = $random(seed);
         config_source(4'(i), r, {31'd0, r[8] | r[9]}, {r[31:2], 1'b0, r[4]});
      end
      for (int i = 0; i < `PIC_TOTAL_INT; i++) begin
         check_readback(4'(i));
      end
      set_order(1'b0);
      reg_read(`PIC_BASE_ADDR + 32'h0000_6000, rd);
      check_val("picm_rd_data (none)", rd, 32'd0);
      reg_read(reg_addr(`PIC_CONFIG_OFS, 4'd1), rd);
      check_val("picm_rd_data (none)", rd, 32'd0);

      random_rounds(40);

      // Edge source: a one-cycle pulse is held until cleared
      idle = idle_sources() & ~16'h0020;
      apply_sources(idle, 4'd0, 4'd0);   // Source 5 low before it turns edge type
      config_source(4'd5, 32'd9, 32'd1, 32'd2);
      idle = idle_sources();
      apply_sources(idle, 4'd0, 4'd0);
      check_outputs(16'h0000);
      @(posedge clk);
      extintsrc_req <= idle | 16'h0020;
      @(posedge clk);
      extintsrc_req <= idle;
      apply_sources(idle, 4'd0, 4'd0);
      check_outputs(16'h0020);
      reg_read(reg_addr(`PIC_PEND_OFS, 4'd0), rd);
      check_val("picm_rd_data (pending)", rd, 32'h0000_0020);
      reg_write(reg_addr(`PIC_GW_CLEAR_OFS, 4'd5), 32'd0);
      repeat (2) @(posedge clk);
      @(negedge clk);
      check_outputs(16'h0000);
      config_source(4'd5, 32'd9, 32'd1, 32'd0);

      // Inverted source pends while its input is low
      config_source(4'd7, 32'd12, 32'd1, 32'd1);
      idle = idle_sources();
      apply_sources(idle & ~16'h0080, 4'd3, 4'd2);
      check_outputs(level_pending(idle & ~16'h0080));

      // Wake-up on the most urgent level in both orders
      config_source(4'd3, 32'd15, 32'd1, 32'd0);
      idle = idle_sources();
      apply_sources(idle | 16'h0008, 4'd0, 4'd0);
      check_outputs(level_pending(idle | 16'h0008));
      set_order(1'b1);
      config_source(4'd3, 32'd0, 32'd1, 32'd0);
      apply_sources(idle | 16'h0008, 4'd15, 4'd15);
      check_outputs(level_pending(idle | 16'h0008));

      random_rounds(20);

      print_summary();
      if (errors == 0 && UUT.u_assert.fail_count == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

`default_nettype wire
